// ==== flist.f ====
rtl/mips_pkg.sv
rtl/mips_fetch.sv
rtl/mips_control.sv
rtl/mips_regfile.sv
rtl/mips_execute.sv
rtl/mips_mem_wb.sv
rtl/mips_core.sv
tests/tb_mips_core.sv

// ==== rtl/mips_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_control import mips_pkg::*; (
    input  word_t      i_instr,
    output logic       o_reg_write,
    output logic       o_mem_to_reg,
    output logic       o_mem_write,
    output logic       o_branch,
    output logic       o_nbranch,
    output logic       o_alu_src,
    output logic       o_reg_dst,
    output alu_class_t o_alu_class,
    output word_t      o_imm
);

    logic [5:0] opcode;
    logic       sign_ext;

    assign opcode = i_instr[31:26];

    always_comb begin
        o_reg_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_mem_write  = 1'b0;
        o_branch     = 1'b0;
        o_nbranch    = 1'b0;
        o_alu_src    = 1'b0;
        o_reg_dst    = 1'b0;
        o_alu_class  = ALU_CLASS_ADD;
        sign_ext     = 1'b1;
        case (opcode)
            OP_RTYPE: begin
                o_reg_write = 1'b1;
                o_reg_dst   = 1'b1;
                o_alu_class = ALU_CLASS_FUNCT;
            end
            OP_ADDI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
            end
            OP_SLTI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_class = ALU_CLASS_SLT_IMM;
            end
            // Logical immediates are zero extended
            OP_ANDI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_class = ALU_CLASS_AND_IMM;
                sign_ext    = 1'b0;
            end
            OP_ORI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_class = ALU_CLASS_OR_IMM;
                sign_ext    = 1'b0;
            end
            OP_LW: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = 1'b1;
                o_alu_src    = 1'b1;
            end
            OP_SW: begin
                o_mem_write = 1'b1;
                o_alu_src   = 1'b1;
            end
            // Branches compare by subtraction
            OP_BEQ: begin
                o_branch    = 1'b1;
                o_alu_class = ALU_CLASS_SUB;
            end
            OP_BNE: begin
                o_nbranch   = 1'b1;
                o_alu_class = ALU_CLASS_SUB;
            end
            default: ;
        endcase
    end

    assign o_imm = sign_ext ? {{16{i_instr[15]}}, i_instr[15:0]} : {16'b0, i_instr[15:0]};

endmodule

`default_nettype wire

// ==== rtl/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; (
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_imem_we,
    input  imem_addr_t i_imem_addr,
    input  word_t      i_imem_data,
    input  reg_addr_t  i_dbg_reg,
    input  dmem_addr_t i_dbg_mem_addr,
    output word_t      o_pc,
    output word_t      o_dbg_reg_data,
    output word_t      o_dbg_mem_data
);

    // IF/ID
    word_t      ifid_instr, ifid_pc4;
    // Decode
    logic       ctl_reg_write, ctl_mem_to_reg, ctl_mem_write, ctl_branch, ctl_nbranch;
    logic       ctl_alu_src, ctl_reg_dst;
    alu_class_t ctl_alu_class;
    word_t      ctl_imm, rs_data, rt_data;
    // EX/MEM
    word_t      exmem_alu, exmem_store, exmem_target;
    reg_addr_t  exmem_dest;
    logic       exmem_reg_write, exmem_mem_to_reg, exmem_mem_write;
    logic       exmem_branch, exmem_nbranch, exmem_zero;
    // Branch and writeback feedback
    logic       branch_taken, wb_we;
    word_t      branch_target, wb_data;
    reg_addr_t  wb_addr;

    mips_fetch u_fetch (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .i_imem_we       (i_imem_we),
        .i_imem_addr     (i_imem_addr),
        .i_imem_data     (i_imem_data),
        .o_pc            (o_pc),
        .o_ifid_instr    (ifid_instr),
        .o_ifid_pc4      (ifid_pc4)
    );

    mips_control u_control (
        .i_instr      (ifid_instr),
        .o_reg_write  (ctl_reg_write),
        .o_mem_to_reg (ctl_mem_to_reg),
        .o_mem_write  (ctl_mem_write),
        .o_branch     (ctl_branch),
        .o_nbranch    (ctl_nbranch),
        .o_alu_src    (ctl_alu_src),
        .o_reg_dst    (ctl_reg_dst),
        .o_alu_class  (ctl_alu_class),
        .o_imm        (ctl_imm)
    );

    mips_regfile u_regfile (
        .clk        (clk),
        .i_rs       (ifid_instr[25:21]),
        .i_rt       (ifid_instr[20:16]),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .i_we       (wb_we),
        .i_wr_addr  (wb_addr),
        .i_wr_data  (wb_data),
        .i_dbg_addr (i_dbg_reg),
        .o_dbg_data (o_dbg_reg_data)
    );

    mips_execute u_execute (
        .clk                (clk),
        .i_rst              (i_rst),
        .i_instr            (ifid_instr),
        .i_pc4              (ifid_pc4),
        .i_reg_write        (ctl_reg_write),
        .i_mem_to_reg       (ctl_mem_to_reg),
        .i_mem_write        (ctl_mem_write),
        .i_branch           (ctl_branch),
        .i_nbranch          (ctl_nbranch),
        .i_alu_src          (ctl_alu_src),
        .i_reg_dst          (ctl_reg_dst),
        .i_alu_class        (ctl_alu_class),
        .i_imm              (ctl_imm),
        .i_rs_data          (rs_data),
        .i_rt_data          (rt_data),
        .i_wb_we            (wb_we),
        .i_wb_addr          (wb_addr),
        .i_wb_data          (wb_data),
        .o_exmem_alu        (exmem_alu),
        .o_exmem_store      (exmem_store),
        .o_exmem_target     (exmem_target),
        .o_exmem_dest       (exmem_dest),
        .o_exmem_reg_write  (exmem_reg_write),
        .o_exmem_mem_to_reg (exmem_mem_to_reg),
        .o_exmem_mem_write  (exmem_mem_write),
        .o_exmem_branch     (exmem_branch),
        .o_exmem_nbranch    (exmem_nbranch),
        .o_exmem_zero       (exmem_zero)
    );

    mips_mem_wb u_mem_wb (
        .clk                (clk),
        .i_rst              (i_rst),
        .i_exmem_alu        (exmem_alu),
        .i_exmem_store      (exmem_store),
        .i_exmem_target     (exmem_target),
        .i_exmem_dest       (exmem_dest),
        .i_exmem_reg_write  (exmem_reg_write),
        .i_exmem_mem_to_reg (exmem_mem_to_reg),
        .i_exmem_mem_write  (exmem_mem_write),
        .i_exmem_branch     (exmem_branch),
        .i_exmem_nbranch    (exmem_nbranch),
        .i_exmem_zero       (exmem_zero),
        .i_dbg_mem_addr     (i_dbg_mem_addr),
        .o_dbg_mem_data     (o_dbg_mem_data),
        .o_branch_taken     (branch_taken),
        .o_branch_target    (branch_target),
        .o_wb_we            (wb_we),
        .o_wb_addr          (wb_addr),
        .o_wb_data          (wb_data)
    );

endmodule

`default_nettype wire

// ==== rtl/mips_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_execute import mips_pkg::*; (
    input  logic       clk,
    input  logic       i_rst,
    input  word_t      i_instr,
    input  word_t      i_pc4,
    input  logic       i_reg_write,
    input  logic       i_mem_to_reg,
    input  logic       i_mem_write,
    input  logic       i_branch,
    input  logic       i_nbranch,
    input  logic       i_alu_src,
    input  logic       i_reg_dst,
    input  alu_class_t i_alu_class,
    input  word_t      i_imm,
    input  word_t      i_rs_data,
    input  word_t      i_rt_data,
    input  logic       i_wb_we,
    input  reg_addr_t  i_wb_addr,
    input  word_t      i_wb_data,
    output word_t      o_exmem_alu,
    output word_t      o_exmem_store,
    output word_t      o_exmem_target,
    output reg_addr_t  o_exmem_dest,
    output logic       o_exmem_reg_write,
    output logic       o_exmem_mem_to_reg,
    output logic       o_exmem_mem_write,
    output logic       o_exmem_branch,
    output logic       o_exmem_nbranch,
    output logic       o_exmem_zero
);

    logic       ex_reg_write, ex_mem_to_reg, ex_mem_write, ex_branch, ex_nbranch;
    logic       ex_alu_src, ex_reg_dst;
    alu_class_t ex_alu_class;
    word_t      ex_pc4, ex_imm, ex_rs_data, ex_rt_data;
    reg_addr_t  ex_rs, ex_rt, ex_rd;
    fwd_sel_t   fwd_a, fwd_b;
    alu_op_t    alu_op;
    word_t      rs_val, rt_val, op_b, alu_y;

    ////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            ex_reg_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_branch     <= 1'b0;
            ex_nbranch    <= 1'b0;
        end else begin
            ex_reg_write  <= i_reg_write;
            ex_mem_to_reg <= i_mem_to_reg;
            ex_mem_write  <= i_mem_write;
            ex_branch     <= i_branch;
            ex_nbranch    <= i_nbranch;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_src   <= i_alu_src;
        ex_reg_dst   <= i_reg_dst;
        ex_alu_class <= i_alu_class;
        ex_pc4       <= i_pc4;
        ex_imm       <= i_imm;
        ex_rs_data   <= i_rs_data;
        ex_rt_data   <= i_rt_data;
        ex_rs        <= i_instr[25:21];
        ex_rt        <= i_instr[20:16];
        ex_rd        <= i_instr[15:11];
    end

    ////////////////////////////////////////
    // Forwarding where EX/MEM wins over WB
    ////////////////////////////////////////
    function automatic fwd_sel_t fwd_pick(input reg_addr_t src, input logic mem_we,
                                          input reg_addr_t mem_dst, input logic wb_we,
                                          input reg_addr_t wb_dst);
        if (src == '0) begin
            return FWD_REG;
        end
        if (mem_we && mem_dst == src) begin
            return FWD_EXMEM;
        end
        if (wb_we && wb_dst == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a = fwd_pick(ex_rs, o_exmem_reg_write, o_exmem_dest, i_wb_we, i_wb_addr);
    assign fwd_b = fwd_pick(ex_rt, o_exmem_reg_write, o_exmem_dest, i_wb_we, i_wb_addr);

    always_comb begin
        case (fwd_a)
            FWD_EXMEM: rs_val = o_exmem_alu;
            FWD_WB:    rs_val = i_wb_data;
            default:   rs_val = ex_rs_data;
        endcase
        case (fwd_b)
            FWD_EXMEM: rt_val = o_exmem_alu;
            FWD_WB:    rt_val = i_wb_data;
            default:   rt_val = ex_rt_data;
        endcase
    end

    assign op_b = ex_alu_src ? ex_imm : rt_val;

    ////////////////////////////////////////
    // ALU control and ALU
    ////////////////////////////////////////
    // Funct and shamt come from the low immediate bits of an R-type word
    always_comb begin
        case (ex_alu_class)
            ALU_CLASS_SUB:     alu_op = ALU_SUB;
            ALU_CLASS_SLT_IMM: alu_op = ALU_SLT;
            ALU_CLASS_AND_IMM: alu_op = ALU_AND;
            ALU_CLASS_OR_IMM:  alu_op = ALU_OR;
            ALU_CLASS_FUNCT: begin
                case (ex_imm[5:0])
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    default: alu_op = ALU_ADD;
                endcase
            end
            default:           alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_y = rs_val - op_b;
            ALU_AND: alu_y = rs_val & op_b;
            ALU_OR:  alu_y = rs_val | op_b;
            ALU_SLT: alu_y = ($signed(rs_val) < $signed(op_b)) ? 32'd1 : 32'd0;
            ALU_SLL: alu_y = op_b << ex_imm[10:6];
            default: alu_y = rs_val + op_b;
        endcase
    end

    ////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_exmem_reg_write  <= 1'b0;
            o_exmem_mem_to_reg <= 1'b0;
            o_exmem_mem_write  <= 1'b0;
            o_exmem_branch     <= 1'b0;
            o_exmem_nbranch    <= 1'b0;
        end else begin
            o_exmem_reg_write  <= ex_reg_write;
            o_exmem_mem_to_reg <= ex_mem_to_reg;
            o_exmem_mem_write  <= ex_mem_write;
            o_exmem_branch     <= ex_branch;
            o_exmem_nbranch    <= ex_nbranch;
        end
    end

    always_ff @(posedge clk) begin
        o_exmem_alu    <= alu_y;
        o_exmem_zero   <= (alu_y == '0);
        o_exmem_store  <= rt_val;
        o_exmem_target <= ex_pc4 + (ex_imm << 2);
        o_exmem_dest   <= ex_reg_dst ? ex_rd : ex_rt;
    end

endmodule

`default_nettype wire

// ==== rtl/mips_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_fetch import mips_pkg::*; (
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_branch_taken,
    input  word_t      i_branch_target,
    input  logic       i_imem_we,
    input  imem_addr_t i_imem_addr,
    input  word_t      i_imem_data,
    output word_t      o_pc,
    output word_t      o_ifid_instr,
    output word_t      o_ifid_pc4
);

    word_t      pc;
    word_t      pc_plus4;
    word_t      fetch_instr;
    imem_addr_t fetch_idx;

    word_t imem [IMEM_WORDS];

    assign pc_plus4  = pc + 32'd4;
    assign fetch_idx = pc[7:2];

    ////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc <= '0;
        end else if (i_branch_taken) begin
            pc <= i_branch_target;
        end else begin
            pc <= pc_plus4;
        end
    end

    // Debug port is the only writer
    always_ff @(posedge clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    assign fetch_instr = imem[fetch_idx];

    ////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////
    // Cleared word decodes as a NOP
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ifid_instr <= '0;
        end else begin
            o_ifid_instr <= fetch_instr;
        end
    end

    always_ff @(posedge clk) begin
        o_ifid_pc4 <= pc_plus4;
    end

    assign o_pc = pc;

endmodule

`default_nettype wire

// ==== rtl/mips_mem_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_mem_wb import mips_pkg::*; (
    input  logic       clk,
    input  logic       i_rst,
    input  word_t      i_exmem_alu,
    input  word_t      i_exmem_store,
    input  word_t      i_exmem_target,
    input  reg_addr_t  i_exmem_dest,
    input  logic       i_exmem_reg_write,
    input  logic       i_exmem_mem_to_reg,
    input  logic       i_exmem_mem_write,
    input  logic       i_exmem_branch,
    input  logic       i_exmem_nbranch,
    input  logic       i_exmem_zero,
    input  dmem_addr_t i_dbg_mem_addr,
    output word_t      o_dbg_mem_data,
    output logic       o_branch_taken,
    output word_t      o_branch_target,
    output logic       o_wb_we,
    output reg_addr_t  o_wb_addr,
    output word_t      o_wb_data
);

    dmem_addr_t mem_idx;
    word_t      load_data;
    word_t      wb_alu;
    word_t      wb_load;
    logic       wb_mem_to_reg;

    word_t dmem [DMEM_WORDS];

    ////////////////////////////////////////
    // Data memory with word access only
    ////////////////////////////////////////
    assign mem_idx = i_exmem_alu[5:2];

    always_ff @(posedge clk) begin
        if (i_exmem_mem_write) begin
            dmem[mem_idx] <= i_exmem_store;
        end
    end

    assign load_data      = dmem[mem_idx];
    assign o_dbg_mem_data = dmem[i_dbg_mem_addr];

    // beq on equal, bne on not equal
    assign o_branch_taken  = (i_exmem_branch & i_exmem_zero) |
                             (i_exmem_nbranch & ~i_exmem_zero);
    assign o_branch_target = i_exmem_target;

    ////////////////////////////////////////
    // MEM/WB register and writeback
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb_we       <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end else begin
            o_wb_we       <= i_exmem_reg_write;
            wb_mem_to_reg <= i_exmem_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        wb_alu    <= i_exmem_alu;
        wb_load   <= load_data;
        o_wb_addr <= i_exmem_dest;
    end

    assign o_wb_data = wb_mem_to_reg ? wb_load : wb_alu;

endmodule

`default_nettype wire

// ==== rtl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_COUNT  = 32;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [4:0]        reg_addr_t;
    typedef logic [5:0]        imem_addr_t;
    typedef logic [3:0]        dmem_addr_t;

    ////////////////////////////////////////
    // Opcodes and R-type funct codes
    ////////////////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    ////////////////////////////////////////
    // Operation selects
    ////////////////////////////////////////
    // Coarse class from the decoder that execute refines
    typedef enum logic [2:0] {
        ALU_CLASS_ADD,
        ALU_CLASS_SUB,
        ALU_CLASS_FUNCT,
        ALU_CLASS_SLT_IMM,
        ALU_CLASS_AND_IMM,
        ALU_CLASS_OR_IMM
    } alu_class_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_WB
    } fwd_sel_t;

endpackage

`default_nettype wire

// ==== rtl/mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_regfile import mips_pkg::*; (
    input  logic      clk,
    input  reg_addr_t i_rs,
    input  reg_addr_t i_rt,
    output word_t     o_rs_data,
    output word_t     o_rt_data,
    input  logic      i_we,
    input  reg_addr_t i_wr_addr,
    input  word_t     i_wr_data,
    input  reg_addr_t i_dbg_addr,
    output word_t     o_dbg_data
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (i_we) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Write-through so decode sees a result written in the same cycle
    assign o_rs_data = (i_rs == '0)                  ? '0        :
                       (i_we && i_wr_addr == i_rs)   ? i_wr_data :
                                                       regs[i_rs];
    assign o_rt_data = (i_rt == '0)                  ? '0        :
                       (i_we && i_wr_addr == i_rt)   ? i_wr_data :
                                                       regs[i_rt];

    assign o_dbg_data = (i_dbg_addr == '0) ? '0 : regs[i_dbg_addr];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_mips_core -o sim_tb

output="$(./obj_dir/sim_tb)"
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    exit 1
fi

// ==== tests/tb_mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core import mips_pkg::*; ();

    localparam int SEED = 32'h8a06_abbe;

    logic       clk;
    logic       i_rst;
    logic       i_imem_we;
    imem_addr_t i_imem_addr;
    word_t      i_imem_data;
    reg_addr_t  i_dbg_reg;
    dmem_addr_t i_dbg_mem_addr;
    word_t      o_pc;
    word_t      o_dbg_reg_data;
    word_t      o_dbg_mem_data;

    word_t prog [$];
    int    gap;
    word_t loop_pc;
    int    opnd [10];

    // Reference model state
    word_t m_reg [REG_COUNT];
    bit    reg_known [REG_COUNT];
    word_t m_mem [DMEM_WORDS];
    bit    mem_known [DMEM_WORDS];

    int checks       = 0;
    int value_errors = 0;
    int reset_errors = 0;
    int other_errors = 0;
    int cycles       = 0;
    int cycle_limit  = 10;
    int seed_discard;

    mips_core UUT (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_imem_we      (i_imem_we),
        .i_imem_addr    (i_imem_addr),
        .i_imem_data    (i_imem_data),
        .i_dbg_reg      (i_dbg_reg),
        .i_dbg_mem_addr (i_dbg_mem_addr),
        .o_pc           (o_pc),
        .o_dbg_reg_data (o_dbg_reg_data),
        .o_dbg_mem_data (o_dbg_mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
    end

    initial begin
        wait (cycles > cycle_limit);
        $display("Timeout: run exceeded %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // PC is back at zero one cycle after any reset edge
    assert property (@(posedge clk) i_rst |=> (o_pc == 32'd0))
        else begin
            reset_errors++;
            $display("PC was not zero in the cycle after reset");
        end

    ////////////////////////////////////////
    // Assembler
    ////////////////////////////////////////
    function automatic int rand16();
        return int'($urandom & 32'hffff);
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
        for (int n = 0; n < gap; n++) begin
            prog.push_back('0);
        end
    endtask

    task automatic emit_r(input logic [5:0] fn, input int rd, input int rs, input int rt,
                          input int sh);
        emit({OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn});
    endtask

    task automatic emit_i(input logic [5:0] op, input int rt, input int rs, input int imm);
        emit({op, rs[4:0], rt[4:0], imm[15:0]});
    endtask

    // Branch-to-self ends the program and the rest of memory holds NOPs
    task automatic finish_program();
        loop_pc = word_t'(4 * prog.size());
        prog.push_back({OP_BEQ, 5'd0, 5'd0, 16'hffff});
    endtask

    task automatic pick_operands();
        for (int n = 0; n < 10; n++) begin
            opnd[n] = rand16();
        end
        // Bit 15 set where sign and zero extension differ
        opnd[2] = opnd[2] | 32'h8000;
        opnd[5] = opnd[5] | 32'h8000;
        opnd[6] = opnd[6] | 32'h8000;
        opnd[7] = opnd[7] | 32'h8000;
        opnd[8] = opnd[8] | 32'h8000;
        opnd[4] = 1 + int'($urandom % 31);
    endtask

    task automatic build_alu_chain(input int spacing);
        prog.delete();
        gap = spacing;
        emit_i(OP_ADDI, 1, 0, opnd[0]);
        emit_i(OP_ORI, 2, 0, opnd[1]);
        emit_i(OP_ADDI, 3, 1, opnd[2]);
        emit_r(FN_ADD, 4, 1, 2, 0);
        emit_r(FN_SUB, 5, 4, 3, 0);
        emit_r(FN_AND, 6, 5, 2, 0);
        emit_r(FN_OR, 7, 6, 5, 0);
        emit_r(FN_SLT, 8, 5, 4, 0);
        emit_r(FN_SLL, 9, 0, 7, opnd[4]);
        emit_i(OP_SLTI, 10, 9, opnd[5]);
        emit_i(OP_ANDI, 11, 5, opnd[6]);
        emit_i(OP_ORI, 12, 5, opnd[7]);
        emit_i(OP_ADDI, 13, 9, opnd[8]);
        emit_r(FN_SLT, 14, 4, 5, 0);
        finish_program();
    endtask

    task automatic build_mem_test();
        int base;
        int idx;
        prog.delete();
        gap = 0;
        base = int'($urandom % 16);
        for (int k = 0; k < 4; k++) begin
            idx = (base + 5 * k) % 16;
            emit_i(OP_ORI, 2, 0, rand16());
            emit_r(FN_SLL, 2, 0, 2, 16);
            emit_i(OP_ORI, 2, 2, rand16());
            emit_i(OP_SW, 2, 0, idx * 4);
        end
        for (int k = 0; k < 4; k++) begin
            emit_i(OP_LW, 20 + k, 0, ((base + 5 * k) % 16) * 4);
        end
        // Load result used at distance 2
        emit('0);
        emit_r(FN_ADD, 24, 23, 20, 0);
        finish_program();
    endtask

    // Three delay NOPs and then the instruction that a taken branch skips
    task automatic branch_case(input logic [5:0] op, input int rs, input int rt,
                               input int marker);
        emit_i(op, rt, rs, 4);
        emit('0);
        emit('0);
        emit('0);
        emit_i(OP_ADDI, marker, 0, 99);
    endtask

    task automatic build_branch_test();
        prog.delete();
        gap = 0;
        emit_i(OP_ADDI, 1, 0, rand16());
        emit_i(OP_ADDI, 2, 1, 0);
        emit_i(OP_ADDI, 3, 1, 1);
        for (int m = 10; m < 14; m++) begin
            emit_i(OP_ADDI, m, 0, 1);
        end
        branch_case(OP_BEQ, 1, 2, 10);
        branch_case(OP_BEQ, 1, 3, 11);
        branch_case(OP_BNE, 1, 3, 12);
        branch_case(OP_BNE, 1, 2, 13);
        finish_program();
    endtask

    task automatic build_zero_reg_test();
        prog.delete();
        gap = 0;
        emit_i(OP_ADDI, 1, 0, rand16() | 1);
        emit_i(OP_ADDI, 0, 1, rand16());
        emit_r(FN_OR, 0, 1, 1, 0);
        emit_r(FN_ADD, 15, 0, 0, 0);
        emit_r(FN_ADD, 16, 0, 1, 0);
        finish_program();
    endtask

    ////////////////////////////////////////
    // Sequential reference model
    ////////////////////////////////////////
    task automatic model_write(input reg_addr_t r, input word_t v);
        if (r != 5'd0) begin
            m_reg[r]     = v;
            reg_known[r] = 1'b1;
        end
    endtask

    // Delay slots hold NOPs, so branches act at once here
    task automatic run_model(input string name);
        int         pc;
        word_t      w, a, b, sx, zx, addr;
        reg_addr_t  rs, rt, rd;
        dmem_addr_t mi;
        pc = 0;
        for (int steps = 0; steps <= 256; steps++) begin
            if (steps == 256 || pc < 0 || pc / 4 >= prog.size()) begin
                other_errors++;
                $display("Model for %s ran off the program at PC %0d", name, pc);
                break;
            end
            w = prog[pc / 4];
            if (word_t'(pc) == loop_pc) begin
                break;
            end
            rs   = w[25:21];
            rt   = w[20:16];
            rd   = w[15:11];
            a    = m_reg[rs];
            b    = m_reg[rt];
            sx   = {{16{w[15]}}, w[15:0]};
            zx   = {16'h0000, w[15:0]};
            addr = a + sx;
            mi   = addr[5:2];
            pc   = pc + 4;
            case (w[31:26])
                OP_RTYPE: begin
                    case (w[5:0])
                        FN_ADD: model_write(rd, a + b);
                        FN_SUB: model_write(rd, a - b);
                        FN_AND: model_write(rd, a & b);
                        FN_OR:  model_write(rd, a | b);
                        FN_SLT: model_write(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        FN_SLL: model_write(rd, b << w[10:6]);
                        default: ;
                    endcase
                end
                OP_ADDI: model_write(rt, a + sx);
                OP_SLTI: model_write(rt, ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0);
                OP_ANDI: model_write(rt, a & zx);
                OP_ORI:  model_write(rt, a | zx);
                OP_LW:   model_write(rt, m_mem[mi]);
                OP_SW: begin
                    m_mem[mi]     = b;
                    mem_known[mi] = 1'b1;
                end
                OP_BEQ: if (a == b) pc = pc + 4 * int'($signed(sx));
                OP_BNE: if (a != b) pc = pc + 4 * int'($signed(sx));
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////
    // Test sequencing and checks
    ////////////////////////////////////////
    task automatic check_value(input string name, input string what, input word_t exp_v,
                               input word_t act_v);
        checks++;
        assert (act_v === exp_v)
            else begin
                value_errors++;
                $display("ERROR %s: %s expected %08h actual %08h", name, what, exp_v, act_v);
            end
    endtask

    task automatic load_program();
        for (int a = 0; a < IMEM_WORDS; a++) begin
            i_imem_we   = 1'b1;
            i_imem_addr = a[5:0];
            i_imem_data = (a < prog.size()) ? prog[a] : '0;
            @(negedge clk);
        end
        i_imem_we = 1'b0;
    endtask

    task automatic check_state(input string name);
        for (int r = 0; r < REG_COUNT; r++) begin
            if (reg_known[r]) begin
                i_dbg_reg = r[4:0];
                @(negedge clk);
                check_value(name, $sformatf("r%0d", r), m_reg[r], o_dbg_reg_data);
            end
        end
        for (int m = 0; m < DMEM_WORDS; m++) begin
            if (mem_known[m]) begin
                i_dbg_mem_addr = m[3:0];
                @(negedge clk);
                check_value(name, $sformatf("mem[%0d]", m), m_mem[m], o_dbg_mem_data);
            end
        end
    endtask

    task automatic run_test(input string name, input bit check_pc);
        int visits;
        run_model(name);
        cycle_limit += 4 + IMEM_WORDS + 4 * prog.size() + REG_COUNT + DMEM_WORDS + 20;
        i_rst = 1'b1;
        repeat (2) @(negedge clk);
        // Core held in reset while the old program is overwritten
        load_program();
        repeat (2) @(negedge clk);
        i_rst = 1'b0;
        if (check_pc) begin
            for (int n = 0; n < 8; n++) begin
                check_value(name, "pc", word_t'(4 * n), o_pc);
                @(negedge clk);
            end
        end
        visits = 0;
        while (visits < 3) begin
            @(negedge clk);
            if (o_pc == loop_pc) begin
                visits++;
            end
        end
        check_state(name);
    endtask

    initial begin
        seed_discard   = $urandom(SEED);
        i_rst          = 1'b1;
        i_imem_we      = 1'b0;
        i_imem_addr    = '0;
        i_imem_data    = '0;
        i_dbg_reg      = '0;
        i_dbg_mem_addr = '0;
        m_reg[0]       = '0;
        reg_known[0]   = 1'b1;

        pick_operands();
        build_alu_chain(2);
        run_test("alu_spaced", 1'b1);
        build_alu_chain(0);
        run_test("alu_forward", 1'b0);
        build_mem_test();
        run_test("load_store", 1'b0);
        build_branch_test();
        run_test("branch", 1'b0);
        build_zero_reg_test();
        run_test("zero_reg", 1'b0);

        $display("Checks: %0d, value errors: %0d, reset errors: %0d, other errors: %0d",
                 checks, value_errors, reset_errors, other_errors);
        if (value_errors + reset_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
